// File: flist.f
+incdir+src
src/pageTablePkg.sv
src/pageFailPkg.sv
src/pageAddressMap.sv
src/pageTableRam.sv
src/pageDirectory.sv
src/pageParity.sv
src/pageFailCtl.sv
src/pager.sv
testbench/pagerTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= pagerTb
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
PASS_MSG ?= PASS: all tests
VFLAGS ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: testbench/pagerTb.sv
`timescale 1ns/100ps
`include "pager_defs.svh"

module pagerTb;

  import pageTablePkg::*;
  import pageFailPkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int N_WORDS = 16;
  localparam int N_RANDOM = 48;
  // Reset and directed steps, then five cycles per word and two per random step
  localparam int TEST_CYCLES = 32 + 5 * N_WORDS + 2 * N_RANDOM;
  localparam int MARGIN = 50;
  localparam int FIRST_PAGE_BIT = 13;
  localparam logic [0:2] IS_OK = 3'b100;
  localparam logic [0:2] IS_REFILL = 3'b010;
  localparam logic [0:2] IS_FAIL = 3'b001;

  logic clk;
  logic rstN;
  logic refValid;
  logic [0:`PG_VPN_W-1] vpn;
  logic user;
  logic write;
  logic paged;
  logic ptWr;
  ptWord ptIn;
  logic mbPar;
  logic dirClear;
  logic pageOk;
  logic pageRefill;
  logic pageFail;
  logic [0:`PG_PPN_W-1] ppn;
  logic [0:`PG_FAIL_W-1] pfCode;

  // Expected result of the lookup being driven, and its copy one cycle on
  logic [0:2] expKind;
  logic [0:2] kindQ;
  logic [0:`PG_PPN_W-1] expPpn;
  logic [0:`PG_PPN_W-1] ppnQ;
  logic [0:`PG_FAIL_W-1] expCode;
  logic [0:`PG_FAIL_W-1] codeQ;
  logic [0:`PG_FAIL_W-1] heldCode;
  logic lookupQ;

  // Shadow page table and directory
  ptWord shadowWord [0:(1 << `PG_IDX_W)-1];
  logic [0:`PG_TAG_W-1] shadowTag [0:(1 << `PG_IDX_W)-1];
  logic shadowValid [0:(1 << `PG_IDX_W)-1];
  logic shadowLeftOk [0:(1 << `PG_IDX_W)-1];

  logic [0:`PG_VPN_W-1] pages [$];
  logic [0:`PG_VPN_W-1] probe;
  int seedSink;

  pager UUT (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic stopRun(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1, "Run stopped on first error");
  endtask

  task automatic reportMismatch(input string name, input string got, input string exp);
    stopRun($sformatf("Fail at %0t: %s is %s, expected %s", $time, name, got, exp));
  endtask

  function automatic logic addrBit(input logic [0:`PG_VPN_W-1] pageNum, input int n);
    return pageNum[n - FIRST_PAGE_BIT];
  endfunction

  // Address bits 18 to 25, with exec folded into bit 19 and bit 17 into bit 20
  function automatic logic [0:`PG_IDX_W-1] tableIndex(input logic [0:`PG_VPN_W-1] pageNum,
                                                       input logic isUser);
    logic [0:`PG_IDX_W-1] idx;
    for (int k = 0; k < `PG_IDX_W; k++) begin
      idx[k] = addrBit(pageNum, 18 + k);
    end
    idx[1] = addrBit(pageNum, 19) ^ !isUser;
    idx[2] = addrBit(pageNum, 20) ^ addrBit(pageNum, 17);
    return idx;
  endfunction

  function automatic logic [0:`PG_TAG_W-1] tagOf(input logic [0:`PG_VPN_W-1] pageNum,
                                                 input logic isUser);
    logic [0:`PG_TAG_W-1] t;
    t[0] = isUser;
    for (int k = 1; k < `PG_TAG_W; k++) begin
      t[k] = addrBit(pageNum, 12 + k);
    end
    return t;
  endfunction

  function automatic logic randomBit();
    logic [31:0] r;
    r = $urandom;
    return r[0];
  endfunction

  function automatic logic [0:`PG_VPN_W-1] randomPage();
    logic [31:0] r;
    r = $urandom;
    return r[`PG_VPN_W-1:0];
  endfunction

  function automatic ptWord makeWord(input logic acc0, input logic wr0,
                                     input logic acc1, input logic wr1);
    ptWord w;
    logic [31:0] r;
    r = $urandom;
    w.pair[0] = r[`PG_HALF_W-1:0];
    r = $urandom;
    w.pair[1] = r[`PG_HALF_W-1:0];
    w.pair[0][ENT_ACCESS] = acc0;
    w.pair[0][ENT_WRITABLE] = wr0;
    w.pair[1][ENT_ACCESS] = acc1;
    w.pair[1][ENT_WRITABLE] = wr1;
    return w;
  endfunction

  task automatic writeWord(input logic [0:`PG_VPN_W-1] pageNum, input logic isUser,
                           input ptWord w, input logic flipPar);
    logic [0:`PG_IDX_W-1] idx;
    logic par;
    idx = tableIndex(pageNum, isUser);
    // Correct buffer parity makes all 37 bits odd
    par = ~^w.whole ^ flipPar;
    shadowWord[idx] = w;
    shadowTag[idx] = tagOf(pageNum, isUser);
    shadowValid[idx] = 1'b1;
    shadowLeftOk[idx] = ^{w.whole, par};
    @(posedge clk);
    refValid <= 1'b0;
    dirClear <= 1'b0;
    ptWr <= 1'b1;
    vpn <= pageNum;
    user <= isUser;
    ptIn <= w;
    mbPar <= par;
  endtask

  task automatic lookup(input logic [0:`PG_VPN_W-1] pageNum, input logic isUser,
                        input logic isWrite, input logic isPaged);
    logic [0:`PG_IDX_W-1] idx;
    logic [0:`PG_HALF_W-1] ent;
    logic parGood;
    logic [0:2] kind;
    logic [0:`PG_PPN_W-1] ppnE;
    logic [0:`PG_FAIL_W-1] code;
    idx = tableIndex(pageNum, isUser);
    ent = shadowWord[idx].pair[pageNum[`PG_VPN_W-1]];
    // Right half always keeps good parity
    parGood = pageNum[`PG_VPN_W-1] || shadowLeftOk[idx];
    code = '0;
    code[PF_PARITY] = !parGood;
    code[PF_ACCESS] = ent[ENT_ACCESS];
    code[PF_WRITABLE] = ent[ENT_WRITABLE];
    code[PF_SOFTWARE] = ent[ENT_SOFTWARE];
    code[PF_WRITE] = isWrite;
    ppnE = ent[ENT_PPN +: ENT_PPN_W];
    if (!isPaged) begin
      kind = IS_OK;
      ppnE = pageNum[`PG_VPN_W-`PG_PPN_W +: `PG_PPN_W];
    end else if (!shadowValid[idx] || shadowTag[idx] != tagOf(pageNum, isUser)) begin
      kind = IS_REFILL;
    end else if (!parGood || !ent[ENT_ACCESS] || (isWrite && !ent[ENT_WRITABLE])) begin
      kind = IS_FAIL;
      heldCode = code;
    end else begin
      kind = IS_OK;
    end
    @(posedge clk);
    refValid <= 1'b1;
    ptWr <= 1'b0;
    dirClear <= 1'b0;
    vpn <= pageNum;
    user <= isUser;
    write <= isWrite;
    paged <= isPaged;
    expKind <= kind;
    expPpn <= ppnE;
    expCode <= heldCode;
  endtask

  task automatic clearDirectory();
    for (int i = 0; i < (1 << `PG_IDX_W); i++) begin
      shadowValid[i] = 1'b0;
    end
    @(posedge clk);
    refValid <= 1'b0;
    ptWr <= 1'b0;
    dirClear <= 1'b1;
  endtask

  task automatic idle();
    @(posedge clk);
    refValid <= 1'b0;
    ptWr <= 1'b0;
    dirClear <= 1'b0;
  endtask

  always @(posedge clk) begin
    lookupQ <= rstN && refValid;
    kindQ <= expKind;
    ppnQ <= expPpn;
    codeQ <= expCode;
  end

  checkResult: assert property (@(posedge clk) disable iff (!rstN)
    {pageOk, pageRefill, pageFail} == (lookupQ ? kindQ : 3'b000))
    else reportMismatch("{pageOk,pageRefill,pageFail}",
      $sformatf("%b", $sampled({pageOk, pageRefill, pageFail})),
      $sformatf("%b", $sampled(lookupQ ? kindQ : 3'b000)));

  checkPpn: assert property (@(posedge clk) disable iff (!rstN)
    lookupQ && kindQ == IS_OK |-> ppn == ppnQ)
    else reportMismatch("ppn", $sformatf("%h", $sampled(ppn)), $sformatf("%h", $sampled(ppnQ)));

  // Held between fails, so checked on every cycle
  checkCode: assert property (@(posedge clk) disable iff (!rstN)
    pfCode == codeQ)
    else reportMismatch("pfCode", $sformatf("%b", $sampled(pfCode)),
      $sformatf("%b", $sampled(codeQ)));

  initial begin
    #((TEST_CYCLES + MARGIN) * CLK_PERIOD);
    stopRun("Watchdog expired before the tests finished");
  end

  initial begin
    seedSink = $urandom(32'h2e82);
    rstN = 1'b0;
    refValid = 1'b0;
    vpn = '0;
    user = 1'b0;
    write = 1'b0;
    paged = 1'b0;
    ptWr = 1'b0;
    ptIn = '0;
    mbPar = 1'b0;
    dirClear = 1'b0;
    expKind = '0;
    expPpn = '0;
    expCode = '0;
    heldCode = '0;
    for (int i = 0; i < (1 << `PG_IDX_W); i++) begin
      shadowValid[i] = 1'b0;
    end
    repeat (3) @(posedge clk);
    rstN <= 1'b1;

    // Unpaged pass-through, then misses on an empty directory
    repeat (8) lookup(randomPage(), randomBit(), randomBit(), 1'b0);
    repeat (8) lookup(randomPage(), 1'b1, randomBit(), 1'b1);

    repeat (N_WORDS) begin
      pages.push_back(randomPage());
      writeWord(pages[$], 1'b1, makeWord(1'b1, 1'b1, 1'b1, 1'b1), 1'b0);
    end
    // Even and odd halves back to back, then the exec twin
    foreach (pages[i]) begin
      lookup({pages[i][0:`PG_VPN_W-2], 1'b0}, 1'b1, randomBit(), 1'b1);
      lookup({pages[i][0:`PG_VPN_W-2], 1'b1}, 1'b1, 1'b0, 1'b1);
      lookup(pages[i], 1'b0, 1'b0, 1'b1);
    end

    // Write-protected left half, no-access right half
    probe = randomPage();
    writeWord(probe, 1'b1, makeWord(1'b1, 1'b0, 1'b0, 1'b1), 1'b0);
    lookup({probe[0:`PG_VPN_W-2], 1'b0}, 1'b1, 1'b1, 1'b1);
    lookup({probe[0:`PG_VPN_W-2], 1'b1}, 1'b1, 1'b0, 1'b1);
    lookup({probe[0:`PG_VPN_W-2], 1'b0}, 1'b1, 1'b0, 1'b1);
    lookup(randomPage(), 1'b0, 1'b0, 1'b1);

    // Bad buffer parity spoils only the left half
    probe = randomPage();
    writeWord(probe, 1'b1, makeWord(1'b1, 1'b1, 1'b1, 1'b1), 1'b1);
    lookup({probe[0:`PG_VPN_W-2], 1'b0}, 1'b1, 1'b0, 1'b1);
    lookup({probe[0:`PG_VPN_W-2], 1'b1}, 1'b1, 1'b1, 1'b1);

    idle();
    clearDirectory();
    foreach (pages[i]) begin
      lookup(pages[i], 1'b1, 1'b0, 1'b1);
    end

    repeat (N_RANDOM) begin
      if ($urandom_range(3) == 0) begin
        pages.push_back(randomPage());
        writeWord(pages[$], randomBit(),
                  makeWord(randomBit(), randomBit(), randomBit(), randomBit()),
                  $urandom_range(7) == 0);
      end
      probe = pages[$urandom_range(pages.size() - 1)];
      lookup({probe[0:`PG_VPN_W-2], randomBit()}, randomBit(), randomBit(),
             $urandom_range(7) != 0);
    end

    idle();
    repeat (2) @(posedge clk);
    $display("PASS: all tests");
    $finish;
  end

endmodule

// File: src/pager.sv
`timescale 1ns/100ps
`include "pager_defs.svh"

module pager (
  input logic clk,
  input logic rstN,
  input logic refValid,
  input logic [0:`PG_VPN_W-1] vpn,
  input logic user,
  input logic write,
  input logic paged,
  input logic ptWr,
  input pageTablePkg::ptWord ptIn,
  input logic mbPar,
  input logic dirClear,
  output logic pageOk,
  output logic pageRefill,
  output logic pageFail,
  output logic [0:`PG_PPN_W-1] ppn,
  output logic [0:`PG_FAIL_W-1] pfCode
);

  import pageTablePkg::*;

  logic [0:`PG_IDX_W-1] ptIdx;
  logic half;
  logic [0:`PG_TAG_W-1] tag;
  ptWord ptOut;
  logic [0:1] parOut;
  logic [0:1] parIn;
  logic match;
  logic parOk;

  // Half of the lookup now in its result cycle
  logic halfSel;

  pageAddressMap addrMap (
    .vpn(vpn),
    .user(user),
    .ptIdx(ptIdx),
    .half(half),
    .tag(tag)
  );

  pageTableRam ptRam (
    .clk(clk),
    .ptWr(ptWr),
    .ptIdx(ptIdx),
    .ptIn(ptIn),
    .parIn(parIn),
    .ptOut(ptOut),
    .parOut(parOut)
  );

  pageDirectory ptDir (
    .clk(clk),
    .rstN(rstN),
    .ptIdx(ptIdx),
    .tag(tag),
    .ptWr(ptWr),
    .dirClear(dirClear),
    .match(match)
  );

  pageParity ptPar (
    .ptIn(ptIn),
    .mbPar(mbPar),
    .ptOut(ptOut),
    .parOut(parOut),
    .half(halfSel),
    .parIn(parIn),
    .parOk(parOk)
  );

  pageFailCtl failCtl (
    .clk(clk),
    .rstN(rstN),
    .refValid(refValid),
    .user(user),
    .write(write),
    .paged(paged),
    .half(half),
    .match(match),
    .ptOut(ptOut),
    .parOk(parOk),
    .vpn(vpn),
    .pageOk(pageOk),
    .pageRefill(pageRefill),
    .pageFail(pageFail),
    .ppn(ppn),
    .pfCode(pfCode),
    .halfSel(halfSel)
  );

endmodule

// File: src/pageFailCtl.sv
`timescale 1ns/100ps
`include "pager_defs.svh"

module pageFailCtl (
  input logic clk,
  input logic rstN,
  input logic refValid,
  input logic user,
  input logic write,
  input logic paged,
  input logic half,
  input logic match,
  input pageTablePkg::ptWord ptOut,
  input logic parOk,
  input logic [0:`PG_VPN_W-1] vpn,
  output logic pageOk,
  output logic pageRefill,
  output logic pageFail,
  output logic [0:`PG_PPN_W-1] ppn,
  output logic [0:`PG_FAIL_W-1] pfCode,
  output logic halfSel
);

  import pageTablePkg::*;
  import pageFailPkg::*;

  logic refQ;
  logic pagedQ;
  logic writeQ;
  logic [0:`PG_PPN_W-1] lowQ;

  logic [0:`PG_HALF_W-1] entry;
  logic pagedRef;
  logic pagedHit;
  logic parBad;
  logic noAccess;
  logic wrProt;
  logic [0:`PG_FAIL_W-1] pfNext;
  logic [0:`PG_FAIL_W-1] pfHold;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      refQ <= 1'b0;
    end else begin
      refQ <= refValid;
    end
  end

  // Request fields line up with the table read
  always_ff @(posedge clk) begin
    pagedQ <= paged;
    writeQ <= write;
    halfSel <= half;
    lowQ <= vpn[`PG_VPN_W-`PG_PPN_W +: `PG_PPN_W];
  end

  always_comb begin
    entry = ptOut.pair[halfSel];
    pagedRef = refQ && pagedQ;
    pagedHit = pagedRef && match;

    // Fail causes in priority order
    parBad = pagedHit && !parOk;
    noAccess = pagedHit && parOk && !entry[ENT_ACCESS];
    wrProt = pagedHit && parOk && entry[ENT_ACCESS] && writeQ && !entry[ENT_WRITABLE];

    pageFail = parBad || noAccess || wrProt;
    pageRefill = pagedRef && !match;
    pageOk = (refQ && !pagedQ) || (pagedHit && !pageFail);

    // Unpaged passes the low page bits straight through
    ppn = pagedQ ? entry[ENT_PPN +: ENT_PPN_W] : lowQ;
  end

  always_comb begin
    pfNext = '0;
    pfNext[PF_PARITY] = !parOk;
    pfNext[PF_ACCESS] = entry[ENT_ACCESS];
    pfNext[PF_WRITABLE] = entry[ENT_WRITABLE];
    pfNext[PF_SOFTWARE] = entry[ENT_SOFTWARE];
    pfNext[PF_WRITE] = writeQ;
  end

  // New code shows during the fail pulse, held after it
  always_ff @(posedge clk) begin
    if (!rstN) begin
      pfHold <= '0;
    end else if (pageFail) begin
      pfHold <= pfNext;
    end
  end

  assign pfCode = pageFail ? pfNext : pfHold;

  oneResult: assert property (@(posedge clk) disable iff (!rstN)
    refValid |=> $onehot({pageOk, pageRefill, pageFail}))
    else $error("lookup did not end in exactly one result");

  noStrayResult: assert property (@(posedge clk) disable iff (!rstN)
    !refValid |=> !(pageOk || pageRefill || pageFail))
    else $error("result pulse without a lookup");

  reqKnown: assert property (@(posedge clk) disable iff (!rstN)
    refValid |-> !$isunknown({user, write, paged, vpn}))
    else $error("lookup started with unknown request fields");

endmodule

// File: src/pageParity.sv
`timescale 1ns/100ps
`include "pager_defs.svh"

module pageParity (
  input pageTablePkg::ptWord ptIn,
  input logic mbPar,
  input pageTablePkg::ptWord ptOut,
  input logic [0:1] parOut,
  input logic half,
  output logic [0:1] parIn,
  output logic parOk
);

  logic rightOdd;
  logic [0:`PG_HALF_W-1] selEntry;

  // Only one word parity comes with the buffer.
  // Right bit completes odd parity of its own half,
  // left bit is what remains of the word parity
  always_comb begin
    rightOdd = ^ptIn.pair[1];
    parIn[1] = ~rightOdd;
    parIn[0] = rightOdd ^ mbPar;
  end

  // Entry read back, checked with its own stored bit
  assign selEntry = ptOut.pair[half];
  assign parOk = ^{selEntry, parOut[half]};

endmodule

// File: src/pageDirectory.sv
`timescale 1ns/100ps
`include "pager_defs.svh"

module pageDirectory (
  input logic clk,
  input logic rstN,
  input logic [0:`PG_IDX_W-1] ptIdx,
  input logic [0:`PG_TAG_W-1] tag,
  input logic ptWr,
  input logic dirClear,
  output logic match
);

  localparam int DEPTH = 1 << `PG_IDX_W;

  logic [0:`PG_TAG_W-1] tagMem [0:DEPTH-1];
  logic [0:DEPTH-1] valid;

  always_ff @(posedge clk) begin
    if (ptWr) begin
      tagMem[ptIdx] <= tag;
    end
  end

  // Clear wins over a write in the same cycle
  always_ff @(posedge clk) begin
    if (!rstN || dirClear) begin
      valid <= '0;
    end else if (ptWr) begin
      valid[ptIdx] <= 1'b1;
    end
  end

  // A lookup that meets a clear misses as well
  always_ff @(posedge clk) begin
    if (!rstN) begin
      match <= 1'b0;
    end else begin
      match <= !dirClear && valid[ptIdx] && (tagMem[ptIdx] == tag);
    end
  end

  clearMisses: assert property (@(posedge clk) disable iff (!rstN)
    dirClear |=> !match)
    else $error("directory hit right after clear");

endmodule

// File: src/pageTableRam.sv
`timescale 1ns/100ps
`include "pager_defs.svh"

module pageTableRam (
  input logic clk,
  input logic ptWr,
  input logic [0:`PG_IDX_W-1] ptIdx,
  input pageTablePkg::ptWord ptIn,
  input logic [0:1] parIn,
  output pageTablePkg::ptWord ptOut,
  output logic [0:1] parOut
);

  import pageTablePkg::*;

  localparam int DEPTH = 1 << `PG_IDX_W;

  ptWord mem [0:DEPTH-1];

  // One stored parity bit per half
  logic [0:1] parMem [0:DEPTH-1];

  // Whole-word writes only
  always_ff @(posedge clk) begin
    if (ptWr) begin
      mem[ptIdx] <= ptIn;
      parMem[ptIdx] <= parIn;
    end
  end

  // Registered read, every cycle
  always_ff @(posedge clk) begin
    ptOut <= mem[ptIdx];
    parOut <= parMem[ptIdx];
  end

  ptWrIdxKnown: assert property (@(posedge clk) ptWr |-> !$isunknown(ptIdx))
    else $error("page table written at unknown index");

endmodule

// File: src/pageAddressMap.sv
`timescale 1ns/100ps
`include "pager_defs.svh"

module pageAddressMap (
  input logic [0:`PG_VPN_W-1] vpn,
  input logic user,
  output logic [0:`PG_IDX_W-1] ptIdx,
  output logic half,
  output logic [0:`PG_TAG_W-1] tag
);

  // vpn[0] carries address bit 13, vpn[13] carries bit 26
  localparam int PAGE_BASE = 13;
  localparam int A17 = 17 - PAGE_BASE;
  localparam int A18 = 18 - PAGE_BASE;
  localparam int A19 = 19 - PAGE_BASE;
  localparam int A20 = 20 - PAGE_BASE;

  logic exec;

  assign exec = ~user;

  always_comb begin
    // Straight bits 18 to 25 first
    ptIdx = vpn[A18 +: `PG_IDX_W];

    // Fold exec into bit 19 so user and exec pages land apart
    ptIdx[1] = vpn[A19] ^ exec;
    ptIdx[2] = vpn[A20] ^ vpn[A17];

    // Bit 26 picks the left or right entry
    half = vpn[`PG_VPN_W-1];

    // Tag keeps what the index dropped
    tag = {user, vpn[0:`PG_TAG_W-2]};
  end

endmodule

// File: src/pageFailPkg.sv
package pageFailPkg;

  // Bit index of each fail-code field

  // Entry plus its stored parity bit was not odd
  localparam int PF_PARITY = 0;

  // Copies of the entry bits at the time of the fail
  localparam int PF_ACCESS = 1;
  localparam int PF_WRITABLE = 2;
  localparam int PF_SOFTWARE = 3;

  // Reference was a write
  localparam int PF_WRITE = 4;

  // Number of fields, kept in step with PG_FAIL_W
  localparam int PF_FIELDS = 5;

endpackage

// File: src/pageTablePkg.sv
`include "pager_defs.svh"

package pageTablePkg;

  // One page-table word, bits numbered left to right as on the machine.
  // Left half (pair[0]) maps the even page, right half (pair[1]) the odd one
  typedef union packed {
    logic [0:`PG_WORD_W-1] whole;
    logic [0:1][0:`PG_HALF_W-1] pair;
  } ptWord;

  // Field positions inside one entry
  localparam int ENT_ACCESS = 0;
  localparam int ENT_PUBLIC = 1;
  localparam int ENT_WRITABLE = 2;
  localparam int ENT_SOFTWARE = 3;
  localparam int ENT_CACHE = 4;

  // Physical page in entry bits 5 to 17
  localparam int ENT_PPN = 5;
  localparam int ENT_PPN_W = 13;

endpackage

// File: src/pager_defs.svh
`ifndef PAGER_DEFS_SVH
`define PAGER_DEFS_SVH

// Virtual page number, address bits 13 to 26
`define PG_VPN_W 14
`define PG_PPN_W 13

// Page table of 256 words
`define PG_IDX_W 8

// User bit plus address bits 13 to 17
`define PG_TAG_W 6

`define PG_WORD_W 36
`define PG_HALF_W 18
`define PG_FAIL_W 5

`endif
